// ==== fetch_pkg.sv ====
// fetch_pkg: shared sizes, reset address, bus structs and state encodings of the fetch subsystem

package fetch_pkg;

    // ********************
    // memory and reset constants
    // ********************
    localparam int MEM_WORDS = 256;                   // depth of the shared word memory
    localparam int MEM_AW = $clog2(MEM_WORDS);        // word address width
    localparam logic [31:0] START_ADDRESS = 32'h0000_0000;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // ********************
    // structs
    // ********************
    typedef struct packed {
        logic              valid;
        logic [MEM_AW-1:0] addr;                      // word address
        logic [31:0]       wdata;
        logic [3:0]        strb;                      // all zero means a read
    } mem_req_t;

    typedef struct packed {
        logic        jump;
        logic [31:0] jump_target;
        logic        exception_raised;
        logic        interrupt_ack;
        logic        machine_return;
        logic [31:0] mtvec;
        logic [31:0] mepc;
    } redirect_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic [2:0]  tag;                             // path tag at fetch time
    } fetch_pkt_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instruction;
    } issue_t;

    // ********************
    // state encodings
    // ********************
    typedef enum logic [1:0] {ARB_FETCH, ARB_AXI} arb_state_e;

    typedef enum logic [1:0] {AXI_IDLE, AXI_MEM, AXI_RESP} axil_state_e;

endpackage

// ==== shared_ram.sv ====
// shared_ram: single-port synchronous word memory with byte write strobes and one-cycle read
`timescale 1ns/1ps

module shared_ram (
    input  logic                         clk,
    input  logic                         en_i,
    input  logic [3:0]                   we_i,
    input  logic [fetch_pkg::MEM_AW-1:0] addr_i,
    input  logic [31:0]                  wdata_i,
    output logic [31:0]                  rdata_o
);
    import fetch_pkg::*;

    logic [31:0] mem [MEM_WORDS];

    // ********************
    // read and write port
    // ********************
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];   // only strobed bytes change
                end
            end
            rdata_o <= mem[addr_i];                   // old contents on a write cycle
        end
    end

endmodule

// ==== mem_arbiter.sv ====
// mem_arbiter: fixed-priority sharing of the word memory between the AXI port and fetch
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        reset_n,
    input  fetch_pkg::mem_req_t         axi_req_i,
    output logic                        axi_done_o,
    input  logic [31:0]                 fetch_addr_i,
    output logic                        fetch_enable_o,
    output logic                        ram_en_o,
    output logic [3:0]                  ram_we_o,
    output logic [fetch_pkg::MEM_AW-1:0] ram_addr_o,
    output logic [31:0]                 ram_wdata_o
);
    import fetch_pkg::*;

    arb_state_e state_q;
    logic       axi_grant;
    logic       fetch_in_range;

    // the AXI side never owns two cycles in a row
    assign axi_grant = axi_req_i.valid && (state_q == ARB_FETCH);
    assign fetch_in_range = (fetch_addr_i[31:MEM_AW+2] == '0);

    assign fetch_enable_o = !axi_grant;              // fetch freezes while AXI has the memory

    // ********************
    // memory port mux
    // ********************
    // no read is started for a PC outside the memory
    assign ram_en_o = axi_grant || fetch_in_range;
    assign ram_we_o = axi_grant ? axi_req_i.strb : 4'b0000;
    assign ram_addr_o = axi_grant ? axi_req_i.addr : fetch_addr_i[MEM_AW+1:2];
    assign ram_wdata_o = axi_req_i.wdata;

    // records who owned the memory last cycle, and so whose data is on the read port now
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= ARB_FETCH;
        end else if (axi_grant) begin
            state_q <= ARB_AXI;
        end else begin
            state_q <= ARB_FETCH;
        end
    end

    assign axi_done_o = (state_q == ARB_AXI);        // read data of the AXI access is valid now

endmodule

// ==== axil_mem_port.sv ====
// axil_mem_port: AXI4-Lite slave that turns single accesses into shared memory requests
`timescale 1ns/1ps

module axil_mem_port (
    input  logic                clk,
    input  logic                reset_n,
    input  logic [31:0]         axil_awaddr_i,
    input  logic                axil_awvalid_i,
    output logic                axil_awready_o,
    input  logic [31:0]         axil_wdata_i,
    input  logic [3:0]          axil_wstrb_i,
    input  logic                axil_wvalid_i,
    output logic                axil_wready_o,
    output logic [1:0]          axil_bresp_o,
    output logic                axil_bvalid_o,
    input  logic                axil_bready_i,
    input  logic [31:0]         axil_araddr_i,
    input  logic                axil_arvalid_i,
    output logic                axil_arready_o,
    output logic [31:0]         axil_rdata_o,
    output logic [1:0]          axil_rresp_o,
    output logic                axil_rvalid_o,
    input  logic                axil_rready_i,
    output fetch_pkg::mem_req_t mem_req_o,
    input  logic                mem_done_i,
    input  logic [31:0]         mem_rdata_i
);
    import fetch_pkg::*;

    axil_state_e state_q;
    logic        is_write_q;
    logic [1:0]  resp_q;
    logic [31:0] rdata_q;
    logic        idle;
    logic        wr_pending;
    logic        wr_acc;
    logic        rd_acc;
    logic        wr_ok;
    logic        rd_ok;

    assign idle = (state_q == AXI_IDLE);
    assign wr_pending = axil_awvalid_i && axil_wvalid_i;
    assign wr_acc = idle && wr_pending;
    assign rd_acc = idle && axil_arvalid_i && !wr_pending;          // writes go first
    assign wr_ok = (axil_awaddr_i[31:MEM_AW+2] == '0);
    assign rd_ok = (axil_araddr_i[31:MEM_AW+2] == '0);

    // AW and W are taken together so a write is never half accepted
    assign axil_awready_o = wr_acc;
    assign axil_wready_o = wr_acc;
    assign axil_arready_o = idle && !wr_pending;

    // ********************
    // memory request
    // ********************
    always_comb begin
        mem_req_o = '0;
        if (wr_acc && wr_ok) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr = axil_awaddr_i[MEM_AW+1:2];
            mem_req_o.wdata = axil_wdata_i;
            mem_req_o.strb = axil_wstrb_i;
        end else if (rd_acc && rd_ok) begin
            mem_req_o.valid = 1'b1;
            mem_req_o.addr = axil_araddr_i[MEM_AW+1:2];    // low address bits are ignored
        end
    end

    // ********************
    // access FSM
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= AXI_IDLE;
            is_write_q <= 1'b0;
            resp_q <= AXI_RESP_OKAY;
        end else begin
            case (state_q)
                AXI_IDLE: begin
                    if (wr_acc) begin
                        is_write_q <= 1'b1;
                        resp_q <= wr_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
                        state_q <= wr_ok ? AXI_MEM : AXI_RESP;
                    end else if (rd_acc) begin
                        is_write_q <= 1'b0;
                        resp_q <= rd_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
                        state_q <= rd_ok ? AXI_MEM : AXI_RESP;
                    end
                end
                AXI_MEM: begin
                    if (mem_done_i) begin
                        state_q <= AXI_RESP;
                    end
                end
                default: begin
                    if (is_write_q ? axil_bready_i : axil_rready_i) begin
                        state_q <= AXI_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == AXI_MEM) && mem_done_i) begin
            rdata_q <= mem_rdata_i;
        end else if (rd_acc && !rd_ok) begin
            rdata_q <= '0;                            // error reads return zero
        end
    end

    assign axil_bvalid_o = (state_q == AXI_RESP) && is_write_q;
    assign axil_rvalid_o = (state_q == AXI_RESP) && !is_write_q;
    assign axil_bresp_o = resp_q;
    assign axil_rresp_o = resp_q;
    assign axil_rdata_o = rdata_q;

endmodule

// ==== fetch_unit.sv ====
// fetch_unit: program counter with redirect priority, path tag and two-stage aligned fetch packets
`timescale 1ns/1ps

module fetch_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   sys_reset_i,
    input  logic                   enable_i,
    input  fetch_pkg::redirect_t   redirect_i,
    output logic [31:0]            instr_addr_o,
    input  logic [31:0]            instr_data_i,
    output fetch_pkg::fetch_pkt_t  fetch_o,
    output logic [2:0]             live_tag_o
);
    import fetch_pkg::*;

    logic [31:0] pc;
    logic [2:0]  tag;
    logic        trap;
    logic        redirect_any;

    logic [31:0] pc_r;
    logic [31:0] pc_q;
    logic [2:0]  tag_r;
    logic [2:0]  tag_q;
    logic        valid_r;
    logic        valid_q;

    logic        enable_r;
    logic        enable_fall;
    logic        enable_rise;
    logic [31:0] instr_hold;
    logic [31:0] instr_q;

    assign trap = redirect_i.exception_raised || redirect_i.interrupt_ack;
    assign redirect_any = sys_reset_i || redirect_i.machine_return || trap || redirect_i.jump;

    // ********************
    // program counter
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc <= START_ADDRESS;
        end else if (sys_reset_i) begin
            pc <= START_ADDRESS;
        end else if (redirect_i.machine_return) begin
            pc <= redirect_i.mepc;                    // mret wins over a trap
        end else if (trap) begin
            pc <= redirect_i.mtvec;
        end else if (redirect_i.jump) begin
            pc <= redirect_i.jump_target;
        end else if (enable_i) begin
            pc <= pc + 32'd4;
        end
    end

    assign instr_addr_o = pc;

    // every change of path moves the tag on
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag <= '0;
        end else if (redirect_any) begin
            tag <= tag + 3'd1;
        end
    end

    assign live_tag_o = tag;

    // ********************
    // pc and tag alignment
    // ********************
    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_r  <= pc;                              // address sent to memory this cycle
            tag_r <= tag;
            pc_q  <= pc_r;                            // lines up with the returning word
            tag_q <= tag_r;
        end
    end

    // a packet is valid only for enabled cycles on the current path
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_r <= 1'b0;
            valid_q <= 1'b0;
        end else if (redirect_any) begin
            valid_r <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (enable_i) begin
                valid_r <= 1'b1;
            end
            valid_q <= enable_i && valid_r;           // a frozen stage must not repeat
        end
    end

    // ********************
    // stall capture
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    assign enable_fall = !enable_i && enable_r;
    assign enable_rise = enable_i && !enable_r;

    // The word that arrives in the first stalled cycle would otherwise be
    // overwritten by the AXI read data, so it is parked until fetch resumes.
    always_ff @(posedge clk) begin
        if (enable_fall) begin
            instr_hold <= instr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_rise) begin
            instr_q <= instr_hold;                    // replay the parked word
        end else if (enable_i) begin
            instr_q <= instr_data_i;
        end
    end

    assign fetch_o = '{
        valid:       valid_q,
        pc:          pc_q,
        instruction: instr_q,
        tag:         tag_q
    };

endmodule

// ==== issue_filter.sv ====
// issue_filter: passes only fetch packets whose tag matches the live path tag
`timescale 1ns/1ps

module issue_filter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  fetch_pkg::fetch_pkt_t fetch_i,
    input  logic [2:0]            live_tag_i,
    output fetch_pkg::issue_t     issue_o
);
    import fetch_pkg::*;

    logic        current_path;
    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] instr_q;

    // a tag mismatch means a redirect happened after this word was fetched
    assign current_path = fetch_i.valid && (fetch_i.tag == live_tag_i);

    // ********************
    // issue register
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= current_path;
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= fetch_i.pc;
        instr_q <= fetch_i.instruction;
    end

    assign issue_o = '{
        valid:       valid_q,
        pc:          pc_q,
        instruction: instr_q
    };

endmodule

// ==== fetch_top.sv ====
// fetch_top: instruction fetch subsystem with shared memory, AXI4-Lite load port and issue filter
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 sys_reset_i,
    input  fetch_pkg::redirect_t redirect_i,
    input  logic [31:0]          axil_awaddr_i,
    input  logic                 axil_awvalid_i,
    output logic                 axil_awready_o,
    input  logic [31:0]          axil_wdata_i,
    input  logic [3:0]           axil_wstrb_i,
    input  logic                 axil_wvalid_i,
    output logic                 axil_wready_o,
    output logic [1:0]           axil_bresp_o,
    output logic                 axil_bvalid_o,
    input  logic                 axil_bready_i,
    input  logic [31:0]          axil_araddr_i,
    input  logic                 axil_arvalid_i,
    output logic                 axil_arready_o,
    output logic [31:0]          axil_rdata_o,
    output logic [1:0]           axil_rresp_o,
    output logic                 axil_rvalid_o,
    input  logic                 axil_rready_i,
    output fetch_pkg::issue_t    issue_o
);
    import fetch_pkg::*;

    mem_req_t          axi_req;
    logic              axi_done;
    logic              fetch_enable;
    logic [31:0]       instr_addr;
    logic              ram_en;
    logic [3:0]        ram_we;
    logic [MEM_AW-1:0] ram_addr;
    logic [31:0]       ram_wdata;
    logic [31:0]       ram_rdata;                     // shared by both memory clients
    fetch_pkt_t        fetch_pkt;
    logic [2:0]        live_tag;

    fetch_unit u_fetch (
        .clk(clk), .reset_n(reset_n), .sys_reset_i(sys_reset_i),
        .enable_i(fetch_enable), .redirect_i(redirect_i),
        .instr_addr_o(instr_addr), .instr_data_i(ram_rdata),
        .fetch_o(fetch_pkt), .live_tag_o(live_tag)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .reset_n(reset_n),
        .axi_req_i(axi_req), .axi_done_o(axi_done),
        .fetch_addr_i(instr_addr), .fetch_enable_o(fetch_enable),
        .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata)
    );

    shared_ram u_ram (
        .clk(clk), .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr),
        .wdata_i(ram_wdata), .rdata_o(ram_rdata)
    );

    axil_mem_port u_axil (
        .clk(clk), .reset_n(reset_n),
        .axil_awaddr_i(axil_awaddr_i), .axil_awvalid_i(axil_awvalid_i),
        .axil_awready_o(axil_awready_o),
        .axil_wdata_i(axil_wdata_i), .axil_wstrb_i(axil_wstrb_i),
        .axil_wvalid_i(axil_wvalid_i), .axil_wready_o(axil_wready_o),
        .axil_bresp_o(axil_bresp_o), .axil_bvalid_o(axil_bvalid_o),
        .axil_bready_i(axil_bready_i),
        .axil_araddr_i(axil_araddr_i), .axil_arvalid_i(axil_arvalid_i),
        .axil_arready_o(axil_arready_o),
        .axil_rdata_o(axil_rdata_o), .axil_rresp_o(axil_rresp_o),
        .axil_rvalid_o(axil_rvalid_o), .axil_rready_i(axil_rready_i),
        .mem_req_o(axi_req), .mem_done_i(axi_done), .mem_rdata_i(ram_rdata)
    );

    issue_filter u_filter (
        .clk(clk), .reset_n(reset_n),
        .fetch_i(fetch_pkt), .live_tag_i(live_tag), .issue_o(issue_o)
    );

endmodule

// ==== tb_fetch_top.sv ====
// tb_fetch_top: testbench for the fetch subsystem with AXI4-Lite loading, redirects and stalls
`timescale 1ns/1ps

module tb_fetch_top;
    import fetch_pkg::*;

    localparam int CLK_HALF = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int MEM_BYTES = MEM_WORDS * 4;
    localparam int MAX_CYCLES = 4000;                 // about 800 for loading, 700 for the rest

    logic        clk;
    logic        reset_n;
    logic        sys_reset;
    redirect_t   redirect;
    logic [31:0] axil_awaddr;
    logic        axil_awvalid;
    logic        axil_awready;
    logic [31:0] axil_wdata;
    logic [3:0]  axil_wstrb;
    logic        axil_wvalid;
    logic        axil_wready;
    logic [1:0]  axil_bresp;
    logic        axil_bvalid;
    logic        axil_bready;
    logic [31:0] axil_araddr;
    logic        axil_arvalid;
    logic        axil_arready;
    logic [31:0] axil_rdata;
    logic [1:0]  axil_rresp;
    logic        axil_rvalid;
    logic        axil_rready;
    issue_t      issue;

    logic [31:0] model [MEM_WORDS];                   // mirrors every accepted AXI write
    logic [31:0] rng;
    logic [31:0] expected_pc;
    logic [31:0] pending_target;
    logic        pending;
    logic        checking;
    int          pending_age;
    int          idle_cycles;
    int          issued_count;
    int          cycle_count;

    fetch_top dut0 (
        .clk(clk), .reset_n(reset_n), .sys_reset_i(sys_reset), .redirect_i(redirect),
        .axil_awaddr_i(axil_awaddr), .axil_awvalid_i(axil_awvalid),
        .axil_awready_o(axil_awready),
        .axil_wdata_i(axil_wdata), .axil_wstrb_i(axil_wstrb),
        .axil_wvalid_i(axil_wvalid), .axil_wready_o(axil_wready),
        .axil_bresp_o(axil_bresp), .axil_bvalid_o(axil_bvalid), .axil_bready_i(axil_bready),
        .axil_araddr_i(axil_araddr), .axil_arvalid_i(axil_arvalid),
        .axil_arready_o(axil_arready),
        .axil_rdata_o(axil_rdata), .axil_rresp_o(axil_rresp),
        .axil_rvalid_o(axil_rvalid), .axil_rready_i(axil_rready),
        .issue_o(issue)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ********************
    // helpers
    // ********************
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // mret first, then a trap to mtvec, then a plain jump
    function automatic logic [31:0] redirect_destination(input redirect_t r);
        if (r.machine_return) begin
            return r.mepc;
        end
        if (r.exception_raised || r.interrupt_ack) begin
            return r.mtvec;
        end
        return r.jump_target;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("** Error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // ********************
    // AXI4-Lite driver
    // ********************
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [1:0] resp;
        logic [1:0] exp_resp;
        exp_resp = (addr < MEM_BYTES) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
        axil_awaddr = addr;
        axil_wdata = data;
        axil_wstrb = strb;
        axil_awvalid = 1'b1;
        axil_wvalid = 1'b1;
        @(negedge clk);
        while (!(axil_awready && axil_wready)) @(negedge clk);
        next_cycle();
        axil_awvalid = 1'b0;
        axil_wvalid = 1'b0;
        axil_bready = 1'b1;
        @(negedge clk);
        while (!axil_bvalid) @(negedge clk);
        resp = axil_bresp;
        next_cycle();
        axil_bready = 1'b0;
        check_value("axil_bresp_o", resp, exp_resp);
        if (exp_resp == AXI_RESP_OKAY) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[addr[MEM_AW+1:2]][8*b +: 8] = data[8*b +: 8];   // strobed bytes only
                end
            end
        end
    endtask

    task automatic check_read(input logic [31:0] addr);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_araddr = addr;
        axil_arvalid = 1'b1;
        @(negedge clk);
        while (!axil_arready) @(negedge clk);
        next_cycle();
        axil_arvalid = 1'b0;
        axil_rready = 1'b1;
        @(negedge clk);
        while (!axil_rvalid) @(negedge clk);
        data = axil_rdata;
        resp = axil_rresp;
        next_cycle();
        axil_rready = 1'b0;
        if (addr < MEM_BYTES) begin
            check_value("axil_rresp_o", resp, AXI_RESP_OKAY);
            check_value("axil_rdata_o", data, model[addr[MEM_AW+1:2]]);   // low bits ignored
        end else begin
            check_value("axil_rresp_o", resp, AXI_RESP_SLVERR);
        end
    endtask

    // ********************
    // redirect stimulus
    // ********************
    task automatic apply_redirect(input redirect_t r);
        redirect = r;
        pending_target = redirect_destination(r);
        pending_age = 0;
        pending = 1'b1;
        next_cycle();
        redirect = '0;
        while (pending) next_cycle();                 // the monitor clears it on the target
    endtask

    task automatic restart_fetch();
        sys_reset = 1'b1;
        pending_target = START_ADDRESS;
        pending_age = 0;
        idle_cycles = 0;
        pending = 1'b1;
        checking = 1'b1;
        next_cycle();
        sys_reset = 1'b0;
        while (pending) next_cycle();
    endtask

    // ********************
    // issue stream monitor
    // ********************
    always @(negedge clk) begin
        if (issue.valid) begin
            if (checking) begin
                if (pending && (issue.pc == pending_target)) begin
                    pending = 1'b0;
                end else begin
                    if (pending) begin
                        assert (pending_age < 2) else begin
                            fail_run("an old-path instruction was issued after a redirect");
                        end
                    end
                    check_value("issue_o.pc", issue.pc, expected_pc);
                end
                if (issue.pc < MEM_BYTES) begin
                    check_value("issue_o.instruction", issue.instruction,
                                model[issue.pc[MEM_AW+1:2]]);
                end
                issued_count = issued_count + 1;
            end
            expected_pc = issue.pc + 32'd4;           // tracked even before checking starts
            idle_cycles = 0;
        end else if (checking) begin
            idle_cycles = idle_cycles + 1;
            assert (idle_cycles < 8) else fail_run("the issue stream stopped for 8 cycles");
        end
        if (checking && pending) begin
            pending_age = pending_age + 1;
            assert (pending_age < 8) else fail_run("a redirect target was never issued");
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("timeout: the run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    // ********************
    // test sequence
    // ********************
    initial begin
        redirect_t  r;
        logic [3:0] strobes [4];
        reset_n = 1'b0;
        sys_reset = 1'b0;
        redirect = '0;
        axil_awaddr = '0;
        axil_awvalid = 1'b0;
        axil_wdata = '0;
        axil_wstrb = '0;
        axil_wvalid = 1'b0;
        axil_bready = 1'b0;
        axil_araddr = '0;
        axil_arvalid = 1'b0;
        axil_rready = 1'b0;
        rng = 32'h13ed;
        expected_pc = START_ADDRESS;
        pending_target = '0;
        pending = 1'b0;
        checking = 1'b0;
        pending_age = 0;
        idle_cycles = 0;
        issued_count = 0;
        cycle_count = 0;
        strobes[0] = 4'b0001;
        strobes[1] = 4'b0110;
        strobes[2] = 4'b1000;
        strobes[3] = 4'b1010;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;

        for (int i = 0; i < MEM_WORDS; i++) begin
            rng = xorshift32(rng);
            axil_write(i * 4, rng, 4'hf);             // program load while fetch runs freely
        end

        // read-back with partial strobes, misaligned reads and out-of-range accesses
        check_read(32'h0000_0000);
        check_read(32'h0000_0016);
        for (int k = 0; k < 4; k++) begin
            rng = xorshift32(rng);
            axil_write(32'h0000_03e8, rng, strobes[k]);
            check_read(32'h0000_03eb);
        end
        axil_write(MEM_BYTES + 8, 32'hdead_beef, 4'hf);   // would alias word 2 if not blocked
        check_read(32'h0000_0008);
        check_read(MEM_BYTES + 4);
        check_read(32'h8000_0000);

        restart_fetch();
        repeat (30) next_cycle();

        r = '0;
        r.jump = 1'b1;
        r.jump_target = 32'h0000_0180;
        apply_redirect(r);
        repeat (15) next_cycle();

        r = '0;                                       // exception beats the jump
        r.jump = 1'b1;
        r.jump_target = 32'h0000_0300;
        r.exception_raised = 1'b1;
        r.mtvec = 32'h0000_0240;
        apply_redirect(r);
        repeat (15) next_cycle();

        r = '0;                                       // mret beats the exception
        r.exception_raised = 1'b1;
        r.machine_return = 1'b1;
        r.mtvec = 32'h0000_0340;
        r.mepc = 32'h0000_00c0;
        apply_redirect(r);
        repeat (15) next_cycle();

        r = '0;
        r.interrupt_ack = 1'b1;
        r.mtvec = 32'h0000_02a0;
        apply_redirect(r);
        repeat (15) next_cycle();

        // random AXI reads steal single memory cycles from fetch
        r = '0;
        r.jump = 1'b1;
        r.jump_target = 32'h0000_0020;
        apply_redirect(r);
        for (int i = 0; i < 30; i++) begin
            rng = xorshift32(rng);
            repeat (rng[1:0]) next_cycle();
            rng = xorshift32(rng);
            check_read({22'd0, rng[MEM_AW+1:0]});
        end
        repeat (10) next_cycle();

        if (issued_count > 100) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("too few instructions were issued");
        end
    end

endmodule

// ==== vlog.f ====
fetch_pkg.sv
shared_ram.sv
mem_arbiter.sv
axil_mem_port.sv
fetch_unit.sv
issue_filter.sv
fetch_top.sv
tb_fetch_top.sv
